// File: source/board_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board-wide constants for the arcade glue logic. Widths, control bit
// positions and the game reset length. Referenced as board_pkg::NAME.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package board_pkg;

    // joystick words
    localparam int JOY_W      = 16;   // raw word from the board
    localparam int GAME_JOY_W = 10;   // 4 directions + 6 buttons
    localparam int PLAYERS    = 4;

    // buttons actually used by the game, shifts start/coin/pause up
    localparam int BUTTONS   = 2;
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    // game expects its controls low when pressed
    localparam logic INPUTS_ACTIVE_LOW = 1'b1;

    // graphics layers with an enable toggle on the keyboard
    localparam int GFX_LAYERS = 4;

    // video
    localparam int COLORW  = 4;   // game colour depth per channel
    localparam int VIDEO_W = 8;   // output colour depth

    // game reset lasts 2**GAME_RST_CNT_W cycles after the last cause
    localparam int GAME_RST_CNT_W = 8;

endpackage

// File: source/key_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded keyboard keys as levels. The top level drives them, the joystick
// mapper and the control panel each read their own share.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface key_if;

    logic [board_pkg::GAME_JOY_W-1:0] key_joy1;
    logic [board_pkg::GAME_JOY_W-1:0] key_joy2;
    logic [board_pkg::PLAYERS-1:0]    key_start;
    logic [board_pkg::PLAYERS-1:0]    key_coin;
    logic                             key_reset;
    logic                             key_pause;
    logic                             key_service;
    logic [board_pkg::GFX_LAYERS-1:0] key_gfx;

    modport mapper (input key_joy1, key_joy2, key_start, key_coin);

    modport panel (input key_reset, key_pause, key_service, key_gfx);

endinterface

// File: source/reset_seq.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game reset stretcher. Any cause (board reset, ROM download, reset
// request, screen flip or soft reset) restarts a fixed-length game reset.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module reset_seq (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic dip_flip,
    input  logic soft_rst,
    output logic game_rst
);

    logic                                last_flip;
    logic [board_pkg::GAME_RST_CNT_W-1:0] rst_cnt;
    logic                                trigger;

    // a flipped screen needs a fresh game start
    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;
    end

    assign trigger = rst | downloading | rst_req | (last_flip != dip_flip) | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != '1) begin
            rst_cnt  <= rst_cnt + 1'b1;   // keep holding
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;   // full count seen
        end
    end

endmodule

// File: source/joy_mapper.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board joysticks to game controls. One sync stage, then keyboard merge,
// optional rotation for players 1 and 2, and polarity for the game.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module joy_mapper (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick2,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick3,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick4,
    input  logic                             rot_en,
    key_if.mapper                            keys,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick3,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick4,
    output logic [board_pkg::PLAYERS-1:0]    game_coin,
    output logic [board_pkg::PLAYERS-1:0]    game_start,
    output logic                             joy_pause
);

    logic [board_pkg::JOY_W-1:0]      joy_sync [board_pkg::PLAYERS];
    logic [board_pkg::PLAYERS-1:0]    coin_raw;
    logic [board_pkg::PLAYERS-1:0]    start_raw;
    logic [board_pkg::GAME_JOY_W-1:0] joy_inv;
    logic [board_pkg::PLAYERS-1:0]    btn_inv;

    // swaps the direction bits for a rotated cabinet
    function automatic logic [board_pkg::GAME_JOY_W-1:0] rotate(
        input logic [board_pkg::GAME_JOY_W-1:0] joy,
        input logic                             rot
    );
        if (!rot)
            return joy;
        return {joy[board_pkg::GAME_JOY_W-1:4], joy[0], joy[1], joy[3], joy[2]};
    endfunction

    assign joy_inv = {board_pkg::GAME_JOY_W{board_pkg::INPUTS_ACTIVE_LOW}};
    assign btn_inv = {board_pkg::PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}};

    always_ff @(posedge clk_sys) begin
        joy_sync[0] <= board_joystick1;
        joy_sync[1] <= board_joystick2;
        joy_sync[2] <= board_joystick3;
        joy_sync[3] <= board_joystick4;
    end

    always_comb begin
        for (int p = 0; p < board_pkg::PLAYERS; p++) begin
            coin_raw[p]  = joy_sync[p][board_pkg::COIN_BIT];
            start_raw[p] = joy_sync[p][board_pkg::START_BIT];
        end
    end

    // pause button on either of the first two sticks
    assign joy_pause = joy_sync[0][board_pkg::PAUSE_BIT] | joy_sync[1][board_pkg::PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= joy_inv;   // all released
            game_joystick2 <= joy_inv;
            game_joystick3 <= joy_inv;
            game_joystick4 <= joy_inv;
            game_coin      <= btn_inv;
            game_start     <= btn_inv;
        end else begin
            game_joystick1 <= joy_inv ^ rotate(
                joy_sync[0][board_pkg::GAME_JOY_W-1:0] | keys.key_joy1, rot_en);
            game_joystick2 <= joy_inv ^ rotate(
                joy_sync[1][board_pkg::GAME_JOY_W-1:0] | keys.key_joy2, rot_en);
            game_joystick3 <= joy_inv ^ joy_sync[2][board_pkg::GAME_JOY_W-1:0];
            game_joystick4 <= joy_inv ^ joy_sync[3][board_pkg::GAME_JOY_W-1:0];
            game_coin      <= btn_inv ^ (coin_raw | keys.key_coin);
            game_start     <= btn_inv ^ (start_raw | keys.key_start);
        end
    end

endmodule

// File: source/panel_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operator panel. Pause and graphics layer toggles on key edges, the
// soft reset strobe and the service switch with game polarity.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module panel_ctrl (
    input  logic                             clk_sys,
    input  logic                             rst,
    key_if.panel                             keys,
    input  logic                             joy_pause,
    output logic                             game_pause,
    output logic                             game_service,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    output logic                             soft_rst
);

    logic                             last_pause;
    logic                             last_joy_pause;
    logic                             last_reset;
    logic [board_pkg::GFX_LAYERS-1:0] last_gfx;
    logic                             pause_edge;

    // previous cycle copy of every key watched for an edge
    always_ff @(posedge clk_sys) begin
        last_pause     <= keys.key_pause;
        last_joy_pause <= joy_pause;
        last_reset     <= keys.key_reset;
        last_gfx       <= keys.key_gfx;
    end

    assign pause_edge = (keys.key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            game_service <= board_pkg::INPUTS_ACTIVE_LOW;
            gfx_en       <= '1;   // every layer visible
            soft_rst     <= 1'b0;
        end else begin
            soft_rst     <= keys.key_reset & ~last_reset;   // one cycle only
            game_service <= keys.key_service ^ board_pkg::INPUTS_ACTIVE_LOW;
            if (pause_edge)
                game_pause <= ~game_pause;
            for (int i = 0; i < board_pkg::GFX_LAYERS; i++) begin
                if (keys.key_gfx[i] && !last_gfx[i])
                    gfx_en[i] <= ~gfx_en[i];
            end
        end
    end

endmodule

// File: source/color_expand.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bypass video path. Registers colour and syncs on the pixel enable and
// widens each channel to full depth by repeating its bits from the MSB.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module color_expand #(
    parameter int COLOR_W = board_pkg::COLORW   // 3 to 8
) (
    input  logic                          clk_sys,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic [COLOR_W-1:0]            game_r,
    input  logic [COLOR_W-1:0]            game_g,
    input  logic [COLOR_W-1:0]            game_b,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic                          hs,
    input  logic                          vs,
    output logic [board_pkg::VIDEO_W-1:0] video_r,
    output logic [board_pkg::VIDEO_W-1:0] video_g,
    output logic [board_pkg::VIDEO_W-1:0] video_b,
    output logic                          video_hs,
    output logic                          video_vs,
    output logic                          video_de
);

    // bit i from the top takes channel bit i mod COLOR_W from the top
    function automatic logic [board_pkg::VIDEO_W-1:0] extend(input logic [COLOR_W-1:0] c);
        logic [board_pkg::VIDEO_W-1:0] v;
        for (int i = 0; i < board_pkg::VIDEO_W; i++) begin
            v[board_pkg::VIDEO_W-1-i] = c[COLOR_W-1-(i % COLOR_W)];
        end
        return v;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            video_r  <= extend(game_r);
            video_g  <= extend(game_g);
            video_b  <= extend(game_b);
            video_hs <= hs;
            video_vs <= vs;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst)
            video_de <= 1'b0;
        else if (pxl_cen)
            video_de <= lhbl & lvbl;   // active outside both blankings
    end

endmodule

// File: source/board_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board glue top level. Game reset, control mapping, operator panel and
// bypass video, all in the clk_sys domain with plain ports to the game.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module board_top (
    input  logic                             clk_sys,
    input  logic                             rst,
    // reset causes
    input  logic                             downloading,
    input  logic                             rst_req,
    input  logic                             dip_flip,
    input  logic                             rot_en,
    // board joysticks
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick2,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick3,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick4,
    // decoded keyboard
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy1,
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy2,
    input  logic [board_pkg::PLAYERS-1:0]    key_start,
    input  logic [board_pkg::PLAYERS-1:0]    key_coin,
    input  logic                             key_reset,
    input  logic                             key_pause,
    input  logic                             key_service,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    // game video
    input  logic                             pxl_cen,
    input  logic [board_pkg::COLORW-1:0]     game_r,
    input  logic [board_pkg::COLORW-1:0]     game_g,
    input  logic [board_pkg::COLORW-1:0]     game_b,
    input  logic                             lhbl,
    input  logic                             lvbl,
    input  logic                             hs,
    input  logic                             vs,
    // to the game
    output logic                             game_rst,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick1,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick2,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick3,
    output logic [board_pkg::GAME_JOY_W-1:0] game_joystick4,
    output logic [board_pkg::PLAYERS-1:0]    game_coin,
    output logic [board_pkg::PLAYERS-1:0]    game_start,
    output logic                             game_pause,
    output logic                             game_service,
    output logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    // video out
    output logic [board_pkg::VIDEO_W-1:0]    video_r,
    output logic [board_pkg::VIDEO_W-1:0]    video_g,
    output logic [board_pkg::VIDEO_W-1:0]    video_b,
    output logic                             video_hs,
    output logic                             video_vs,
    output logic                             video_de
);

    logic joy_pause;
    logic soft_rst;

    key_if keys ();

    assign keys.key_joy1    = key_joy1;
    assign keys.key_joy2    = key_joy2;
    assign keys.key_start   = key_start;
    assign keys.key_coin    = key_coin;
    assign keys.key_reset   = key_reset;
    assign keys.key_pause   = key_pause;
    assign keys.key_service = key_service;
    assign keys.key_gfx     = key_gfx;

    reset_seq u_reset (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .downloading (downloading),
        .rst_req     (rst_req),
        .dip_flip    (dip_flip),
        .soft_rst    (soft_rst),
        .game_rst    (game_rst)
    );

    joy_mapper u_joy (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .board_joystick3 (board_joystick3),
        .board_joystick4 (board_joystick4),
        .rot_en          (rot_en),
        .keys            (keys.mapper),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_joystick3  (game_joystick3),
        .game_joystick4  (game_joystick4),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .joy_pause       (joy_pause)
    );

    panel_ctrl u_panel (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .keys         (keys.panel),
        .joy_pause    (joy_pause),
        .game_pause   (game_pause),
        .game_service (game_service),
        .gfx_en       (gfx_en),
        .soft_rst     (soft_rst)
    );

    color_expand #(
        .COLOR_W (board_pkg::COLORW)
    ) u_video (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .game_r   (game_r),
        .game_g   (game_g),
        .game_b   (game_b),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .hs       (hs),
        .vs       (vs),
        .video_r  (video_r),
        .video_g  (video_g),
        .video_b  (video_b),
        .video_hs (video_hs),
        .video_vs (video_vs),
        .video_de (video_de)
    );

endmodule

// File: bench/board_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the board glue. Steps with the DUT on each clock edge,
// compares every output on the falling edge and keeps per-test counts.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module board_checker (
    input  logic                             clk_sys,
    input  logic                             rst,
    input  int                               test_id,
    input  logic                             downloading, rst_req, dip_flip, rot_en,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick1, board_joystick2,
    input  logic [board_pkg::JOY_W-1:0]      board_joystick3, board_joystick4,
    input  logic [board_pkg::GAME_JOY_W-1:0] key_joy1, key_joy2,
    input  logic [board_pkg::PLAYERS-1:0]    key_start, key_coin,
    input  logic                             key_reset, key_pause, key_service,
    input  logic [board_pkg::GFX_LAYERS-1:0] key_gfx,
    input  logic                             pxl_cen, lhbl, lvbl, hs, vs,
    input  logic [board_pkg::COLORW-1:0]     game_r, game_g, game_b,
    input  logic                             game_rst, game_pause, game_service,
    input  logic [board_pkg::GAME_JOY_W-1:0] game_joystick1, game_joystick2,
    input  logic [board_pkg::GAME_JOY_W-1:0] game_joystick3, game_joystick4,
    input  logic [board_pkg::PLAYERS-1:0]    game_coin, game_start,
    input  logic [board_pkg::GFX_LAYERS-1:0] gfx_en,
    input  logic [board_pkg::VIDEO_W-1:0]    video_r, video_g, video_b,
    input  logic                             video_hs, video_vs, video_de,
    output int                               error_count,
    output int                               tests_done,
    output int                               tests_failed
);

    localparam int RST_HOLD = 1 << board_pkg::GAME_RST_CNT_W;   // cycles after last cause

    logic [board_pkg::JOY_W-1:0]      board_joy [board_pkg::PLAYERS];
    logic [board_pkg::JOY_W-1:0]      sync_m [board_pkg::PLAYERS];
    logic [board_pkg::GAME_JOY_W-1:0] joy_m [board_pkg::PLAYERS];
    logic [board_pkg::PLAYERS-1:0]    coin_m, start_m, coin_now, start_now;
    logic [board_pkg::GFX_LAYERS-1:0] gfx_m, prev_gfx;
    logic                             pause_m, service_m, soft_m, joy_pause_now, trig;
    logic                             prev_pause, prev_joy_pause, prev_reset, prev_flip;
    logic [board_pkg::VIDEO_W-1:0]    r_m, g_m, b_m;
    logic                             hs_m, vs_m, de_m;
    logic                             armed = 1'b0;
    logic                             vid_valid = 1'b0;
    int                               since_trig = 0;
    int                               cur_test = 0;
    int                               test_errs = 0;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_stretch";
            2: return "joystick_map";
            3: return "coin_start";
            4: return "panel_toggle";
            5: return "soft_reset";
            6: return "colour_path";
            default: return "unknown";
        endcase
    endfunction

    // keys merged, direction bits turned if asked, then game polarity
    function automatic logic [board_pkg::GAME_JOY_W-1:0] game_word(
        input logic [board_pkg::JOY_W-1:0]      s,
        input logic [board_pkg::GAME_JOY_W-1:0] k,
        input logic                             rot
    );
        logic [board_pkg::GAME_JOY_W-1:0] w;
        logic [board_pkg::GAME_JOY_W-1:0] r;
        w = s[board_pkg::GAME_JOY_W-1:0] | k;
        r = w;
        if (rot) begin
            r[3] = w[0];
            r[2] = w[1];
            r[1] = w[3];
            r[0] = w[2];
        end
        return r ^ {board_pkg::GAME_JOY_W{board_pkg::INPUTS_ACTIVE_LOW}};
    endfunction

    // channel written out again and again, top bits kept
    function automatic logic [board_pkg::VIDEO_W-1:0] widen(
        input logic [board_pkg::COLORW-1:0] c
    );
        logic [31:0] acc;
        int          filled;
        acc = '0;
        filled = 0;
        while (filled < board_pkg::VIDEO_W) begin
            acc = (acc << board_pkg::COLORW) | c;
            filled += board_pkg::COLORW;
        end
        return acc >> (filled - board_pkg::VIDEO_W);
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s %s expected %0h actual %0h", test_name(cur_test), what, exp, act);
            test_errs++;
            error_count++;
        end
    endtask

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    initial begin
        error_count  = 0;
        tests_done   = 0;
        tests_failed = 0;
    end

    always @(posedge clk_sys) begin
        trig = rst | downloading | rst_req | (dip_flip != prev_flip) | soft_m;
        for (int p = 0; p < board_pkg::PLAYERS; p++) begin
            coin_now[p]  = sync_m[p][board_pkg::COIN_BIT];
            start_now[p] = sync_m[p][board_pkg::START_BIT];
        end
        joy_pause_now = sync_m[0][board_pkg::PAUSE_BIT] | sync_m[1][board_pkg::PAUSE_BIT];

        if (rst)
            armed <= 1'b1;
        prev_flip  <= dip_flip;
        prev_reset <= key_reset;
        soft_m     <= !rst && key_reset && !prev_reset;   // strobe after the key edge
        if (trig)
            since_trig <= 0;
        else if (since_trig < RST_HOLD)
            since_trig <= since_trig + 1;

        for (int p = 0; p < board_pkg::PLAYERS; p++) begin
            sync_m[p] <= board_joy[p];
            if (rst)
                joy_m[p] <= game_word('0, '0, 1'b0);   // nothing pressed
        end
        if (rst) begin
            coin_m  <= {board_pkg::PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}};
            start_m <= {board_pkg::PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}};
        end else begin
            joy_m[0] <= game_word(sync_m[0], key_joy1, rot_en);
            joy_m[1] <= game_word(sync_m[1], key_joy2, rot_en);
            joy_m[2] <= game_word(sync_m[2], '0, 1'b0);
            joy_m[3] <= game_word(sync_m[3], '0, 1'b0);
            coin_m   <= (coin_now | key_coin) ^ {board_pkg::PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}};
            start_m  <= (start_now | key_start) ^ {board_pkg::PLAYERS{board_pkg::INPUTS_ACTIVE_LOW}};
        end

        prev_pause     <= key_pause;
        prev_joy_pause <= joy_pause_now;
        prev_gfx       <= key_gfx;
        if (rst) begin
            pause_m   <= 1'b0;
            gfx_m     <= '1;
            service_m <= board_pkg::INPUTS_ACTIVE_LOW;
        end else begin
            if ((key_pause && !prev_pause) || (joy_pause_now && !prev_joy_pause))
                pause_m <= !pause_m;
            gfx_m     <= gfx_m ^ (key_gfx & ~prev_gfx);
            service_m <= key_service ^ board_pkg::INPUTS_ACTIVE_LOW;
        end

        if (pxl_cen) begin
            r_m       <= widen(game_r);
            g_m       <= widen(game_g);
            b_m       <= widen(game_b);
            hs_m      <= hs;
            vs_m      <= vs;
            vid_valid <= 1'b1;   // colour known from here on
        end
        if (rst)
            de_m <= 1'b0;
        else if (pxl_cen)
            de_m <= lhbl && lvbl;
    end

    // outputs settle well before the falling edge
    always @(negedge clk_sys) begin
        if (test_id != cur_test) begin
            if (cur_test != 0) begin
                tests_done++;
                if (test_errs == 0) begin
                    $display("test %s: PASS", test_name(cur_test));
                end else begin
                    tests_failed++;
                    $display("test %s: FAIL, %0d mismatches", test_name(cur_test), test_errs);
                end
            end
            cur_test  = test_id;
            test_errs = 0;
        end
        if (cur_test != 0 && armed) begin
            compare("game_rst", since_trig < RST_HOLD, game_rst);
            compare("game_joystick1", joy_m[0], game_joystick1);
            compare("game_joystick2", joy_m[1], game_joystick2);
            compare("game_joystick3", joy_m[2], game_joystick3);
            compare("game_joystick4", joy_m[3], game_joystick4);
            compare("game_coin", coin_m, game_coin);
            compare("game_start", start_m, game_start);
            compare("game_pause", pause_m, game_pause);
            compare("game_service", service_m, game_service);
            compare("gfx_en", gfx_m, gfx_en);
            compare("video_de", de_m, video_de);
            if (vid_valid) begin
                compare("video_r", r_m, video_r);
                compare("video_g", g_m, video_g);
                compare("video_b", b_m, video_b);
                compare("video_hs", hs_m, video_hs);
                compare("video_vs", vs_m, video_vs);
            end
        end
    end

endmodule

// File: bench/board_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the board glue. Clock, reset, LFSR driven stimulus in
// six tests and a cycle limit; board_checker does the comparing.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module board_tb;

    localparam int RST_WAIT  = 300;   // longest wait for game_rst to fall
    localparam int TRIGGERS  = 4;
    localparam int TRIG_LEN  = 160 + RST_WAIT;   // two pulses, a gap and the release
    localparam int RAND_LEN  = 200;
    localparam int PRESSES   = 2;
    localparam int PRESS_LEN = 12 + RST_WAIT;
    localparam int COLOR_LEN = 200;
    localparam int TOTAL_LEN = RST_WAIT + 10 + TRIGGERS * TRIG_LEN + 3 * RAND_LEN
                             + PRESSES * PRESS_LEN + COLOR_LEN + 5;
    localparam int TIMEOUT   = TOTAL_LEN + TOTAL_LEN / 10;

    logic                             clk_sys;
    logic                             rst;
    logic                             downloading, rst_req, dip_flip, rot_en;
    logic [board_pkg::JOY_W-1:0]      board_joystick1, board_joystick2;
    logic [board_pkg::JOY_W-1:0]      board_joystick3, board_joystick4;
    logic [board_pkg::GAME_JOY_W-1:0] key_joy1, key_joy2;
    logic [board_pkg::PLAYERS-1:0]    key_start, key_coin;
    logic                             key_reset, key_pause, key_service;
    logic [board_pkg::GFX_LAYERS-1:0] key_gfx;
    logic                             pxl_cen, lhbl, lvbl, hs, vs;
    logic [board_pkg::COLORW-1:0]     game_r, game_g, game_b;
    logic                             game_rst, game_pause, game_service;
    logic [board_pkg::GAME_JOY_W-1:0] game_joystick1, game_joystick2;
    logic [board_pkg::GAME_JOY_W-1:0] game_joystick3, game_joystick4;
    logic [board_pkg::PLAYERS-1:0]    game_coin, game_start;
    logic [board_pkg::GFX_LAYERS-1:0] gfx_en;
    logic [board_pkg::VIDEO_W-1:0]    video_r, video_g, video_b;
    logic                             video_hs, video_vs, video_de;
    int                               test_id;
    int                               error_count, tests_done, tests_failed;
    int                               stall_count;
    int                               cycles = 0;
    logic [31:0]                      lfsr;

    board_top dut (.*);

    board_checker chk (.*);

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // which board joystick bits a test moves
    function automatic logic [board_pkg::JOY_W-1:0] joy_mask(input int mode);
        logic [board_pkg::JOY_W-1:0] m;
        m = '0;
        case (mode)
            0: m = '1;
            1: begin
                m[board_pkg::COIN_BIT]  = 1'b1;
                m[board_pkg::START_BIT] = 1'b1;
            end
            default: m[board_pkg::PAUSE_BIT] = 1'b1;
        endcase
        return m;
    endfunction

    // mode 0 sticks and keys, 1 coins and starts, 2 panel keys
    task automatic drive_controls(input int cycles_n, input int mode);
        logic [31:0] r;
        repeat (cycles_n) begin
            @(posedge clk_sys);
            random_bits(16, r);
            board_joystick1 <= r[15:0] & joy_mask(mode);
            random_bits(16, r);
            board_joystick2 <= r[15:0] & joy_mask(mode);
            random_bits(16, r);
            board_joystick3 <= r[15:0] & joy_mask(mode);
            random_bits(16, r);
            board_joystick4 <= r[15:0] & joy_mask(mode);
            random_bits(20, r);
            key_joy1 <= (mode == 0) ? r[9:0] : '0;
            key_joy2 <= (mode == 0) ? r[19:10] : '0;
            random_bits(16, r);
            key_start   <= (mode < 2) ? r[3:0] : '0;
            key_coin    <= (mode < 2) ? r[7:4] : '0;
            key_pause   <= (mode == 2) & r[8];
            key_service <= (mode == 2) & r[9];
            key_gfx     <= (mode == 2) ? r[13:10] : '0;
            if (mode == 0 && r[15:14] == 2'b00)
                rot_en <= ~rot_en;   // turn the cabinet now and then
        end
    endtask

    task automatic pulse_cause(input logic [1:0] sel, input int len);
        @(posedge clk_sys);
        case (sel)
            2'd0: downloading <= 1'b1;
            2'd1: rst_req <= 1'b1;
            default: dip_flip <= ~dip_flip;
        endcase
        repeat (len) @(posedge clk_sys);
        downloading <= 1'b0;
        rst_req     <= 1'b0;
    endtask

    task automatic wait_release();
        int n;
        n = 0;
        repeat (3) @(posedge clk_sys);   // let the cause reach game_rst
        do begin
            @(negedge clk_sys);
            n++;
        end while (game_rst !== 1'b0 && n < RST_WAIT);
        if (game_rst !== 1'b0) begin
            $display("game_rst was still high %0d cycles after the last reset cause", n);
            stall_count++;
        end
        repeat (4) @(posedge clk_sys);
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timed out after %0d cycles before the tests completed", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        lfsr            = 32'hd6fa_63b9;
        stall_count     = 0;
        rst             = 1'b1;
        downloading     = 1'b0;
        rst_req         = 1'b0;
        dip_flip        = 1'b0;
        rot_en          = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_joystick3 = '0;
        board_joystick4 = '0;
        key_joy1        = '0;
        key_joy2        = '0;
        key_start       = '0;
        key_coin        = '0;
        key_reset       = 1'b0;
        key_pause       = 1'b0;
        key_service     = 1'b0;
        key_gfx         = '0;
        pxl_cen         = 1'b0;
        game_r          = '0;
        game_g          = '0;
        game_b          = '0;
        lhbl            = 1'b0;
        lvbl            = 1'b0;
        hs              = 1'b0;
        vs              = 1'b0;
        test_id         = 1;   // reset stretch, from the board reset on
        repeat (2) @(posedge clk_sys);
        rst <= 1'b0;
        wait_release();
        repeat (TRIGGERS) begin
            random_bits(4, r);
            pulse_cause(r[1:0], 1 + r[3:2]);
            random_bits(1, r);
            if (r[0]) begin
                random_bits(9, r);
                repeat (r[6:0]) @(posedge clk_sys);   // restart in mid count
                pulse_cause(r[8:7], 1);
            end
            wait_release();
        end

        test_id <= 2;
        drive_controls(RAND_LEN, 0);
        test_id <= 3;
        drive_controls(RAND_LEN, 1);
        test_id <= 4;
        drive_controls(RAND_LEN, 2);

        test_id <= 5;
        repeat (PRESSES) begin
            random_bits(2, r);
            @(posedge clk_sys);
            key_reset <= 1'b1;
            repeat (1 + r[1:0]) @(posedge clk_sys);
            key_reset <= 1'b0;
            wait_release();
        end

        test_id <= 6;
        repeat (COLOR_LEN) begin
            @(posedge clk_sys);
            random_bits(17, r);
            pxl_cen <= r[0];
            game_r  <= r[4:1];
            game_g  <= r[8:5];
            game_b  <= r[12:9];
            lhbl    <= r[13];
            lvbl    <= r[14];
            hs      <= r[15];
            vs      <= r[16];
        end

        @(posedge clk_sys);
        test_id <= 0;   // closes the last test in the checker
        repeat (2) @(negedge clk_sys);
        $display("%0d tests run, %0d failed, %0d mismatches, %0d stalls",
                 tests_done, tests_failed, error_count, stall_count);
        if (tests_failed == 0 && error_count == 0 && stall_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: verilog.f
source/board_pkg.sv
source/key_if.sv
source/reset_seq.sv
source/joy_mapper.sv
source/panel_ctrl.sv
source/color_expand.sv
source/board_top.sv
bench/board_checker.sv
bench/board_tb.sv
